/* rtl/spu_pkg.sv */
package spu_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int DAT_BITS      = 32;
    localparam int SEL_BITS      = DAT_BITS / 8;
    localparam int MEM_ADDR_BITS = 6;
    localparam int MEM_WORDS     = 1 << MEM_ADDR_BITS;
    localparam int REGION_BITS   = 3;
    localparam int ADR_BITS      = REGION_BITS + MEM_ADDR_BITS;
    localparam int REG_ADR_BITS  = 2;

    typedef logic [DAT_BITS-1:0]      word_t;
    typedef logic [SEL_BITS-1:0]      sel_t;
    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;
    typedef logic [ADR_BITS-1:0]      wb_adr_t;
    typedef logic [REGION_BITS-1:0]   region_t;

    // ------------------------------
    // address map
    // ------------------------------
    localparam region_t REGION_REGS = region_t'(0);
    localparam region_t REGION_SRC0 = region_t'(4);
    localparam region_t REGION_SRC1 = region_t'(5);
    localparam region_t REGION_SUM  = region_t'(6);
    localparam region_t REGION_DIFF = region_t'(7);

    // register offsets inside region 0
    localparam logic [REG_ADR_BITS-1:0] ADR_START = REG_ADR_BITS'(0);
    localparam logic [REG_ADR_BITS-1:0] ADR_DONE  = REG_ADR_BITS'(1);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } core_state_t;

endpackage

/* rtl/spu_wb_decode.sv */
`timescale 1ns/1ns

module spu_wb_decode (
    input  logic             s_wb_clk_i,
    input  logic             s_wb_rst_i,
    input  spu_pkg::wb_adr_t s_wb_adr_i,
    input  logic             s_wb_stb_i,
    input  logic             s_wb_we_i,
    input  spu_pkg::word_t   reg_dat_i,
    input  spu_pkg::word_t   src0_dat_i,
    input  spu_pkg::word_t   src1_dat_i,
    input  spu_pkg::word_t   sum_dat_i,
    input  spu_pkg::word_t   diff_dat_i,
    output logic             reg_stb_o,
    output logic             src0_stb_o,
    output logic             src1_stb_o,
    output logic             sum_stb_o,
    output logic             diff_stb_o,
    output logic             wr_en_o,
    output spu_pkg::word_t   s_wb_dat_o,
    output logic             s_wb_ack_o
);
    import spu_pkg::*;

    region_t region;
    region_t region_q;
    logic    ack_q;

    assign region = s_wb_adr_i[ADR_BITS-1:MEM_ADDR_BITS];

    assign reg_stb_o  = s_wb_stb_i && (region == REGION_REGS);
    assign src0_stb_o = s_wb_stb_i && (region == REGION_SRC0);
    assign src1_stb_o = s_wb_stb_i && (region == REGION_SRC1);
    assign sum_stb_o  = s_wb_stb_i && (region == REGION_SUM);
    assign diff_stb_o = s_wb_stb_i && (region == REGION_DIFF);

    // only the first stb cycle writes, the ack cycle does not
    assign wr_en_o = s_wb_stb_i && s_wb_we_i && !ack_q;

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            ack_q    <= 1'b0;
            region_q <= REGION_REGS;
        end else begin
            ack_q <= s_wb_stb_i && !ack_q;
            if (s_wb_stb_i && !ack_q) begin
                region_q <= region;
            end
        end
    end

    // targets return registered data, so select by the latched region
    always_comb begin
        case (region_q)
            REGION_REGS: s_wb_dat_o = reg_dat_i;
            REGION_SRC0: s_wb_dat_o = src0_dat_i;
            REGION_SRC1: s_wb_dat_o = src1_dat_i;
            REGION_SUM:  s_wb_dat_o = sum_dat_i;
            REGION_DIFF: s_wb_dat_o = diff_dat_i;
            default:     s_wb_dat_o = '0;
        endcase
    end

    assign s_wb_ack_o = ack_q;

    // master must hold stb through the ack cycle
    a_ack_with_stb: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        s_wb_ack_o |-> s_wb_stb_i);

endmodule

/* rtl/spu_ctrl_regs.sv */
`timescale 1ns/1ns

module spu_ctrl_regs (
    input  logic                             s_wb_clk_i,
    input  logic                             s_wb_rst_i,
    input  logic                             reg_stb_i,
    input  logic                             wr_en_i,
    input  logic [spu_pkg::REG_ADR_BITS-1:0] reg_adr_i,
    input  spu_pkg::word_t                   s_wb_dat_i,
    input  spu_pkg::sel_t                    s_wb_sel_i,
    input  logic                             done_i,
    output logic                             start_o,
    output spu_pkg::word_t                   reg_dat_o
);
    import spu_pkg::*;

    logic start_q;
    logic done_q;
    logic wr_lane0;

    // registers only look at bit 0, so lane 0 must be selected
    assign wr_lane0 = reg_stb_i && wr_en_i && s_wb_sel_i[0];

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (wr_lane0 && (reg_adr_i == ADR_START) && s_wb_dat_i[0]) begin
                start_q <= 1'b1;
                done_q  <= 1'b0;
            end
            if (wr_lane0 && (reg_adr_i == ADR_DONE) && !s_wb_dat_i[0]) begin
                done_q <= 1'b0;
            end
            // core completion wins over a clear in the same cycle
            if (done_i) begin
                done_q <= 1'b1;
            end
        end
    end

    // read word lines up with the registered ack
    always_ff @(posedge s_wb_clk_i) begin
        if (reg_adr_i == ADR_DONE) begin
            reg_dat_o <= word_t'(done_q);
        end else begin
            reg_dat_o <= '0;
        end
    end

    assign start_o = start_q;

endmodule

/* rtl/spu_wb_ram.sv */
`timescale 1ns/1ns

module spu_wb_ram (
    input  logic               s_wb_clk_i,
    input  logic               bus_stb_i,
    input  logic               bus_wr_en_i,
    input  spu_pkg::mem_addr_t bus_addr_i,
    input  spu_pkg::sel_t      bus_sel_i,
    input  spu_pkg::word_t     bus_wdat_i,
    input  logic               core_we_i,
    input  spu_pkg::mem_addr_t core_addr_i,
    input  spu_pkg::word_t     core_wdat_i,
    output spu_pkg::word_t     bus_rdat_o,
    output spu_pkg::word_t     core_rdat_o
);
    import spu_pkg::*;

    word_t mem [MEM_WORDS];

    // ------------------------------
    // bus port, byte lanes
    // ------------------------------
    always_ff @(posedge s_wb_clk_i) begin
        if (bus_stb_i && bus_wr_en_i) begin
            for (int b = 0; b < SEL_BITS; b++) begin
                if (bus_sel_i[b]) begin
                    mem[bus_addr_i][b*8 +: 8] <= bus_wdat_i[b*8 +: 8];
                end
            end
        end
        // whole word from the core
        if (core_we_i) begin
            mem[core_addr_i] <= core_wdat_i;
        end
    end

    // ------------------------------
    // registered reads
    // ------------------------------
    always_ff @(posedge s_wb_clk_i) begin
        bus_rdat_o  <= mem[bus_addr_i];
        core_rdat_o <= mem[core_addr_i];
    end

endmodule

/* rtl/spu_core.sv */
`timescale 1ns/1ns

module spu_core (
    input  logic               s_wb_clk_i,
    input  logic               s_wb_rst_i,
    input  logic               start_i,
    input  spu_pkg::word_t     src0_dat_i,
    input  spu_pkg::word_t     src1_dat_i,
    output spu_pkg::mem_addr_t rd_addr_o,
    output logic               wr_en_o,
    output spu_pkg::mem_addr_t wr_addr_o,
    output spu_pkg::word_t     sum_dat_o,
    output spu_pkg::word_t     diff_dat_o,
    output logic               done_o
);
    import spu_pkg::*;

    core_state_t state;
    mem_addr_t   rd_addr_q;
    mem_addr_t   wr_addr_q;
    logic        wr_en_q;
    logic        done_q;

    // ------------------------------
    // sequencer
    // ------------------------------
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            state     <= IDLE;
            rd_addr_q <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state     <= RUN;
                        rd_addr_q <= '0;
                    end
                end
                RUN: begin
                    rd_addr_q <= rd_addr_q + 1'b1;
                    if (rd_addr_q == mem_addr_t'(MEM_WORDS - 1)) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // last write happens in this cycle
                    state  <= IDLE;
                    done_q <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // one stage of delay to match the RAM read latency
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= (state == RUN);
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        wr_addr_q <= rd_addr_q;
    end

    assign rd_addr_o  = rd_addr_q;
    assign wr_en_o    = wr_en_q;
    assign wr_addr_o  = wr_addr_q;
    assign sum_dat_o  = src0_dat_i + src1_dat_i;
    assign diff_dat_o = src0_dat_i - src1_dat_i;
    assign done_o     = done_q;

    a_wr_not_idle: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        wr_en_o |-> (state != IDLE));

    a_done_pulse: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
        done_o |=> !done_o);

endmodule

/* rtl/sram_to_sram_spu.sv */
`timescale 1ns/1ns

module sram_to_sram_spu (
    input  logic             s_wb_clk_i,
    input  logic             s_wb_rst_i,
    input  spu_pkg::wb_adr_t s_wb_adr_i,
    input  spu_pkg::word_t   s_wb_dat_i,
    output spu_pkg::word_t   s_wb_dat_o,
    input  logic             s_wb_we_i,
    input  spu_pkg::sel_t    s_wb_sel_i,
    input  logic             s_wb_stb_i,
    output logic             s_wb_ack_o
);
    import spu_pkg::*;

    logic      reg_stb, src0_stb, src1_stb, sum_stb, diff_stb;
    logic      wr_en;
    word_t     reg_dat, src0_dat, src1_dat, sum_dat, diff_dat;
    mem_addr_t mem_addr;

    logic      start;
    logic      done;
    mem_addr_t core_rd_addr;
    word_t     core_src0, core_src1;
    logic      core_wr_en;
    mem_addr_t core_wr_addr;
    word_t     core_sum, core_diff;

    assign mem_addr = s_wb_adr_i[MEM_ADDR_BITS-1:0];

    // ------------------------------
    // bus side
    // ------------------------------
    spu_wb_decode u_wb_decode (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .s_wb_adr_i (s_wb_adr_i),
        .s_wb_stb_i (s_wb_stb_i),
        .s_wb_we_i  (s_wb_we_i),
        .reg_dat_i  (reg_dat),
        .src0_dat_i (src0_dat),
        .src1_dat_i (src1_dat),
        .sum_dat_i  (sum_dat),
        .diff_dat_i (diff_dat),
        .reg_stb_o  (reg_stb),
        .src0_stb_o (src0_stb),
        .src1_stb_o (src1_stb),
        .sum_stb_o  (sum_stb),
        .diff_stb_o (diff_stb),
        .wr_en_o    (wr_en),
        .s_wb_dat_o (s_wb_dat_o),
        .s_wb_ack_o (s_wb_ack_o)
    );

    spu_ctrl_regs u_ctrl_regs (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .reg_stb_i  (reg_stb),
        .wr_en_i    (wr_en),
        .reg_adr_i  (s_wb_adr_i[REG_ADR_BITS-1:0]),
        .s_wb_dat_i (s_wb_dat_i),
        .s_wb_sel_i (s_wb_sel_i),
        .done_i     (done),
        .start_o    (start),
        .reg_dat_o  (reg_dat)
    );

    // ------------------------------
    // memories
    // ------------------------------
    spu_wb_ram u_ram_src0 (
        .s_wb_clk_i  (s_wb_clk_i),
        .bus_stb_i   (src0_stb),
        .bus_wr_en_i (wr_en),
        .bus_addr_i  (mem_addr),
        .bus_sel_i   (s_wb_sel_i),
        .bus_wdat_i  (s_wb_dat_i),
        .core_we_i   (1'b0),
        .core_addr_i (core_rd_addr),
        .core_wdat_i ('0),
        .bus_rdat_o  (src0_dat),
        .core_rdat_o (core_src0)
    );

    spu_wb_ram u_ram_src1 (
        .s_wb_clk_i  (s_wb_clk_i),
        .bus_stb_i   (src1_stb),
        .bus_wr_en_i (wr_en),
        .bus_addr_i  (mem_addr),
        .bus_sel_i   (s_wb_sel_i),
        .bus_wdat_i  (s_wb_dat_i),
        .core_we_i   (1'b0),
        .core_addr_i (core_rd_addr),
        .core_wdat_i ('0),
        .bus_rdat_o  (src1_dat),
        .core_rdat_o (core_src1)
    );

    spu_wb_ram u_ram_sum (
        .s_wb_clk_i  (s_wb_clk_i),
        .bus_stb_i   (sum_stb),
        .bus_wr_en_i (wr_en),
        .bus_addr_i  (mem_addr),
        .bus_sel_i   (s_wb_sel_i),
        .bus_wdat_i  (s_wb_dat_i),
        .core_we_i   (core_wr_en),
        .core_addr_i (core_wr_addr),
        .core_wdat_i (core_sum),
        .bus_rdat_o  (sum_dat),
        .core_rdat_o ()
    );

    spu_wb_ram u_ram_diff (
        .s_wb_clk_i  (s_wb_clk_i),
        .bus_stb_i   (diff_stb),
        .bus_wr_en_i (wr_en),
        .bus_addr_i  (mem_addr),
        .bus_sel_i   (s_wb_sel_i),
        .bus_wdat_i  (s_wb_dat_i),
        .core_we_i   (core_wr_en),
        .core_addr_i (core_wr_addr),
        .core_wdat_i (core_diff),
        .bus_rdat_o  (diff_dat),
        .core_rdat_o ()
    );

    // ------------------------------
    // core
    // ------------------------------
    spu_core u_core (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .start_i    (start),
        .src0_dat_i (core_src0),
        .src1_dat_i (core_src1),
        .rd_addr_o  (core_rd_addr),
        .wr_en_o    (core_wr_en),
        .wr_addr_o  (core_wr_addr),
        .sum_dat_o  (core_sum),
        .diff_dat_o (core_diff),
        .done_o     (done)
    );

endmodule

/* tb/tb_spu.sv */
`timescale 1ns/1ns

module tb_spu;
    import spu_pkg::*;

    // two runs of 128 writes and 128 reads at 3 cycles each, plus polls,
    // come to about 7 us at 4 ns per cycle
    localparam int WATCHDOG_NS = 20000;
    localparam int ACK_WAIT    = 8;

    logic    clk;
    logic    rst;
    wb_adr_t adr;
    word_t   wdat;
    word_t   rdat;
    logic    we;
    sel_t    sel;
    logic    stb;
    logic    ack;

    int      seed;
    int      err_count;
    int      cycle_cnt;
    word_t   src0_ref [MEM_WORDS];
    word_t   src1_ref [MEM_WORDS];
    word_t   rd_word;
    logic    cmp_req = 1'b0;
    logic    cmp_ack = 1'b0;

    sram_to_sram_spu u_sram_to_sram_spu (
        .s_wb_clk_i (clk),
        .s_wb_rst_i (rst),
        .s_wb_adr_i (adr),
        .s_wb_dat_i (wdat),
        .s_wb_dat_o (rdat),
        .s_wb_we_i  (we),
        .s_wb_sel_i (sel),
        .s_wb_stb_i (stb),
        .s_wb_ack_o (ack)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        #WATCHDOG_NS;
        fail_run("simulation hung, watchdog expired");
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            err_count++;
            fail_run($sformatf("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    function automatic wb_adr_t make_adr(input region_t r, input int unsigned off);
        return {r, mem_addr_t'(off)};
    endfunction

    // sum or difference modulo 2^32
    function automatic word_t expected_word(input word_t a, input word_t b, input bit diff);
        logic [DAT_BITS:0] wide;
        if (diff) begin
            wide = {1'b1, a} - {1'b0, b};
        end else begin
            wide = {1'b0, a} + {1'b0, b};
        end
        return wide[DAT_BITS-1:0];
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input sel_t s);
        word_t res;
        res = old_w;
        for (int b = 0; b < SEL_BITS; b++) begin
            if (s[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // one classic access with stb held through the ack cycle
    task automatic bus_cycle(input logic wr, input wb_adr_t a, input word_t d, input sel_t s,
                             output word_t q);
        int waited;
        waited = 0;
        @(negedge clk);
        adr  = a;
        wdat = d;
        sel  = s;
        we   = wr;
        stb  = 1'b1;
        @(negedge clk);
        while (ack !== 1'b1) begin
            if (waited >= ACK_WAIT) begin
                fail_run($sformatf("no acknowledge for address %h", a));
            end
            waited++;
            @(negedge clk);
        end
        q = rdat;
        // slave samples stb with ack high at the next rising edge
        @(negedge clk);
        if (ack !== 1'b0) begin
            fail_run($sformatf("acknowledge for address %h lasted more than one cycle", a));
        end
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input wb_adr_t a, input word_t d, input sel_t s);
        word_t unused;
        bus_cycle(1'b1, a, d, s, unused);
    endtask

    task automatic wb_read(input wb_adr_t a, output word_t q);
        bus_cycle(1'b0, a, '0, '1, q);
    endtask

    task automatic fill_sources();
        for (int i = 0; i < MEM_WORDS; i++) begin
            src0_ref[i] = $random(seed);
            src1_ref[i] = $random(seed);
            wb_write(make_adr(REGION_SRC0, i), src0_ref[i], '1);
            wb_write(make_adr(REGION_SRC1, i), src1_ref[i], '1);
        end
    endtask

    task automatic start_run();
        wb_write(make_adr(REGION_REGS, ADR_START), 32'h1, 4'h1);
    endtask

    task automatic poll_done();
        int    t0;
        word_t d;
        t0 = cycle_cnt;
        d  = '0;
        while (d[0] !== 1'b1) begin
            if (cycle_cnt - t0 > MEM_WORDS + 50) begin
                fail_run("the run never finished, DONE stayed low");
            end
            wb_read(make_adr(REGION_REGS, ADR_DONE), d);
        end
    endtask

    task automatic request_compare();
        cmp_req = 1'b1;
        wait (cmp_ack === 1'b1);
        cmp_req = 1'b0;
        wait (cmp_ack === 1'b0);
    endtask

    // ------------------------------
    // result comparison
    // ------------------------------
    initial begin : compare_proc
        word_t got;
        forever begin
            wait (cmp_req === 1'b1);
            for (int i = 0; i < MEM_WORDS; i++) begin
                wb_read(make_adr(REGION_SUM, i), got);
                check_word(got, expected_word(src0_ref[i], src1_ref[i], 1'b0),
                           $sformatf("sum word %0d", i));
                wb_read(make_adr(REGION_DIFF, i), got);
                check_word(got, expected_word(src0_ref[i], src1_ref[i], 1'b1),
                           $sformatf("diff word %0d", i));
            end
            cmp_ack = 1'b1;
            wait (cmp_req === 1'b0);
            cmp_ack = 1'b0;
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        adr       = '0;
        wdat      = '0;
        we        = 1'b0;
        sel       = '0;
        stb       = 1'b0;
        seed      = 72;
        err_count = 0;
        cycle_cnt = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        wb_read(make_adr(REGION_REGS, ADR_DONE), rd_word);
        check_word(rd_word, 32'h0, "DONE after reset");
        wb_read(make_adr(REGION_REGS, ADR_START), rd_word);
        check_word(rd_word, 32'h0, "START after reset");

        wb_write(make_adr(REGION_SRC0, 5), 32'h1122_3344, '1);
        wb_read(make_adr(REGION_SRC0, 5), rd_word);
        check_word(rd_word, 32'h1122_3344, "src0 readback");
        wb_write(make_adr(REGION_SRC0, 5), 32'hAABB_CCDD, 4'b0101);
        wb_read(make_adr(REGION_SRC0, 5), rd_word);
        check_word(rd_word, merge_bytes(32'h1122_3344, 32'hAABB_CCDD, 4'b0101),
                   "src0 partial byte write");

        // region 2 is not mapped
        wb_write(make_adr(region_t'(2), 7), 32'hDEAD_BEEF, '1);
        wb_read(make_adr(region_t'(2), 7), rd_word);
        check_word(rd_word, 32'h0, "unmapped region read");

        fill_sources();
        start_run();
        poll_done();
        request_compare();

        wb_write(make_adr(REGION_REGS, ADR_DONE), 32'h0, 4'h1);
        wb_read(make_adr(REGION_REGS, ADR_DONE), rd_word);
        check_word(rd_word, 32'h0, "DONE after clear");

        start_run();
        poll_done();
        wb_read(make_adr(REGION_REGS, ADR_DONE), rd_word);
        check_word(rd_word, 32'h1, "DONE after rerun");

        // done is still set here and start must clear it
        fill_sources();
        start_run();
        wb_read(make_adr(REGION_REGS, ADR_DONE), rd_word);
        check_word(rd_word, 32'h0, "DONE cleared by start");
        poll_done();
        request_compare();

        if (err_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

/* sources.f */
rtl/spu_pkg.sv
rtl/spu_wb_decode.sv
rtl/spu_ctrl_regs.sv
rtl/spu_wb_ram.sv
rtl/spu_core.sv
rtl/sram_to_sram_spu.sv
tb/tb_spu.sv

/* Makefile */
# Verilator build for the stream processing unit testbench

VERILATOR ?= verilator
TOP       ?= tb_spu
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the grep status decides pass or fail
run: compile
	./$(BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
